// File: eth_fifo_defines.svh
`ifndef ETH_FIFO_DEFINES_SVH
`define ETH_FIFO_DEFINES_SVH

// Width of one stream beat in bits
`define ETH_DATA_W 64

// One byte enable per data byte
`define ETH_KEEP_W 8

// Memory address width, 64 words per FIFO
`define ETH_FIFO_AW 6

`endif

// File: eth_fifo_pkg.sv
`default_nettype none

`include "eth_fifo_defines.svh"

package eth_fifo_pkg;

    typedef logic [`ETH_DATA_W-1:0] eth_data_t;
    typedef logic [`ETH_KEEP_W-1:0] eth_keep_t;

    typedef logic [`ETH_FIFO_AW-1:0] fifo_addr_t;

    // Extra top bit flags a wrap, so full and empty differ
    typedef logic [`ETH_FIFO_AW:0] fifo_ptr_t;

    // Stored word laid out as {last, keep, data}
    typedef logic [`ETH_DATA_W+`ETH_KEEP_W:0] fifo_word_t;

endpackage

`default_nettype wire

// File: frame_fifo_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_fifo_defines.svh"

module frame_fifo_ram (
    input  wire                          logic_clk,
    input  wire                          wr_en,
    input  wire eth_fifo_pkg::fifo_addr_t wr_addr,
    input  wire eth_fifo_pkg::fifo_word_t wr_word,
    input  wire                          rd_en,
    input  wire eth_fifo_pkg::fifo_addr_t rd_addr,
    output eth_fifo_pkg::fifo_word_t     rd_word
);
    import eth_fifo_pkg::*;

    fifo_word_t mem [0:(1 << `ETH_FIFO_AW)-1];

    always_ff @(posedge logic_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;
        end
    end

    // Read data holds while rd_en is low
    always_ff @(posedge logic_clk) begin
        if (rd_en) begin
            rd_word <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: frame_fifo_write.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_fifo_defines.svh"

module frame_fifo_write #(
    parameter bit drop_when_full = 1'b0
) (
    input  wire                          logic_clk,
    input  wire                          logic_rst,
    input  wire eth_fifo_pkg::eth_data_t  s_tdata,
    input  wire eth_fifo_pkg::eth_keep_t  s_tkeep,
    input  wire                          s_tvalid,
    input  wire                          s_tlast,
    input  wire                          s_tuser,
    output logic                         s_tready,
    output logic                         wr_en,
    output eth_fifo_pkg::fifo_addr_t     wr_addr,
    output eth_fifo_pkg::fifo_word_t     wr_word,
    input  wire eth_fifo_pkg::fifo_ptr_t  rd_ptr,
    output eth_fifo_pkg::fifo_ptr_t      wr_ptr_commit,
    output logic                         good_frame,
    output logic                         bad_frame,
    output logic                         overflow
);
    import eth_fifo_pkg::*;

    // Only the wrap bit set
    localparam fifo_ptr_t wrap = fifo_ptr_t'(1) << `ETH_FIFO_AW;

    fifo_ptr_t wr_ptr_cur;
    fifo_ptr_t wr_ptr_next;
    logic      drop_frame;
    logic      mem_full;
    logic      frame_full;
    logic      drop_beat;
    logic      accept;

    assign wr_ptr_next = wr_ptr_cur + 1'b1;

    // Same address, opposite wrap bit
    assign mem_full   = (wr_ptr_cur == (rd_ptr ^ wrap));
    assign frame_full = (wr_ptr_cur == (wr_ptr_commit ^ wrap));

    // Transmit side stalls on a full memory unless the frame can never fit
    assign s_tready = drop_when_full || !mem_full || frame_full || drop_frame;

    assign drop_beat = drop_frame || (drop_when_full ? mem_full : frame_full);
    assign accept    = s_tvalid && s_tready;

    assign wr_en   = accept && !drop_beat;
    assign wr_addr = wr_ptr_cur[`ETH_FIFO_AW-1:0];
    assign wr_word = {s_tlast, s_tkeep, s_tdata};

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            wr_ptr_cur    <= '0;
            wr_ptr_commit <= '0;
            drop_frame    <= 1'b0;
            good_frame    <= 1'b0;
            bad_frame     <= 1'b0;
            overflow      <= 1'b0;
        end else begin
            good_frame <= 1'b0;
            bad_frame  <= 1'b0;
            overflow   <= 1'b0;
            if (accept) begin
                if (drop_beat) begin
                    // Swallow the rest of the frame, rewind on its last beat
                    if (s_tlast) begin
                        wr_ptr_cur <= wr_ptr_commit;
                        drop_frame <= 1'b0;
                        overflow   <= 1'b1;
                    end else begin
                        drop_frame <= 1'b1;
                    end
                end else if (s_tlast) begin
                    if (s_tuser) begin
                        wr_ptr_cur <= wr_ptr_commit;
                        bad_frame  <= 1'b1;
                    end else begin
                        wr_ptr_cur    <= wr_ptr_next;
                        wr_ptr_commit <= wr_ptr_next;
                        good_frame    <= 1'b1;
                    end
                end else begin
                    wr_ptr_cur <= wr_ptr_next;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: frame_fifo_read.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_fifo_defines.svh"

module frame_fifo_read (
    input  wire                          logic_clk,
    input  wire                          logic_rst,
    input  wire eth_fifo_pkg::fifo_ptr_t  wr_ptr_commit,
    output eth_fifo_pkg::fifo_ptr_t      rd_ptr,
    output logic                         rd_en,
    output eth_fifo_pkg::fifo_addr_t     rd_addr,
    input  wire eth_fifo_pkg::fifo_word_t rd_word,
    output eth_fifo_pkg::eth_data_t      m_tdata,
    output eth_fifo_pkg::eth_keep_t      m_tkeep,
    output logic                         m_tvalid,
    output logic                         m_tlast,
    input  wire                          m_tready
);
    import eth_fifo_pkg::*;

    logic rd_pending;
    logic empty;
    logic store;

    // Only committed words are visible here
    assign empty = (rd_ptr == wr_ptr_commit);

    // Move the memory word out when the output register frees up
    assign store = rd_pending && (!m_tvalid || m_tready);

    assign rd_en   = !empty && (!rd_pending || store);
    assign rd_addr = rd_ptr[`ETH_FIFO_AW-1:0];

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            rd_ptr     <= '0;
            rd_pending <= 1'b0;
            m_tvalid   <= 1'b0;
        end else begin
            if (rd_en) begin
                rd_ptr     <= rd_ptr + 1'b1;
                rd_pending <= 1'b1;
            end else if (store) begin
                rd_pending <= 1'b0;
            end

            if (store) begin
                m_tvalid <= 1'b1;
            end else if (m_tready) begin
                m_tvalid <= 1'b0;
            end
        end
    end

    // Output payload
    always_ff @(posedge logic_clk) begin
        if (store) begin
            {m_tlast, m_tkeep, m_tdata} <= rd_word;
        end
    end

endmodule

`default_nettype wire

// File: frame_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module frame_fifo #(
    parameter bit drop_when_full = 1'b0
) (
    input  wire                         logic_clk,
    input  wire                         logic_rst,
    input  wire eth_fifo_pkg::eth_data_t s_tdata,
    input  wire eth_fifo_pkg::eth_keep_t s_tkeep,
    input  wire                         s_tvalid,
    input  wire                         s_tlast,
    input  wire                         s_tuser,
    output logic                        s_tready,
    output eth_fifo_pkg::eth_data_t     m_tdata,
    output eth_fifo_pkg::eth_keep_t     m_tkeep,
    output logic                        m_tvalid,
    output logic                        m_tlast,
    input  wire                         m_tready,
    output logic                        good_frame,
    output logic                        bad_frame,
    output logic                        overflow
);
    import eth_fifo_pkg::*;

    logic       wr_en;
    fifo_addr_t wr_addr;
    fifo_word_t wr_word;
    logic       rd_en;
    fifo_addr_t rd_addr;
    fifo_word_t rd_word;
    fifo_ptr_t  rd_ptr;
    fifo_ptr_t  wr_ptr_commit;

    frame_fifo_ram i_ram (
        .logic_clk (logic_clk),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_word   (wr_word),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_word   (rd_word)
    );

    frame_fifo_write #(
        .drop_when_full (drop_when_full)
    ) i_write (
        .logic_clk     (logic_clk),
        .logic_rst     (logic_rst),
        .s_tdata       (s_tdata),
        .s_tkeep       (s_tkeep),
        .s_tvalid      (s_tvalid),
        .s_tlast       (s_tlast),
        .s_tuser       (s_tuser),
        .s_tready      (s_tready),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_word       (wr_word),
        .rd_ptr        (rd_ptr),
        .wr_ptr_commit (wr_ptr_commit),
        .good_frame    (good_frame),
        .bad_frame     (bad_frame),
        .overflow      (overflow)
    );

    frame_fifo_read i_read (
        .logic_clk     (logic_clk),
        .logic_rst     (logic_rst),
        .wr_ptr_commit (wr_ptr_commit),
        .rd_ptr        (rd_ptr),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_word       (rd_word),
        .m_tdata       (m_tdata),
        .m_tkeep       (m_tkeep),
        .m_tvalid      (m_tvalid),
        .m_tlast       (m_tlast),
        .m_tready      (m_tready)
    );

endmodule

`default_nettype wire

// File: eth_frame_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module eth_frame_fifo (
    input  wire                         logic_clk,
    input  wire                         logic_rst,

    input  wire eth_fifo_pkg::eth_data_t tx_axis_tdata,
    input  wire eth_fifo_pkg::eth_keep_t tx_axis_tkeep,
    input  wire                         tx_axis_tvalid,
    output logic                        tx_axis_tready,
    input  wire                         tx_axis_tlast,
    input  wire                         tx_axis_tuser,

    output eth_fifo_pkg::eth_data_t     tx_fifo_axis_tdata,
    output eth_fifo_pkg::eth_keep_t     tx_fifo_axis_tkeep,
    output logic                        tx_fifo_axis_tvalid,
    input  wire                         tx_fifo_axis_tready,
    output logic                        tx_fifo_axis_tlast,

    input  wire eth_fifo_pkg::eth_data_t rx_fifo_axis_tdata,
    input  wire eth_fifo_pkg::eth_keep_t rx_fifo_axis_tkeep,
    input  wire                         rx_fifo_axis_tvalid,
    input  wire                         rx_fifo_axis_tlast,
    input  wire                         rx_fifo_axis_tuser,

    output eth_fifo_pkg::eth_data_t     rx_axis_tdata,
    output eth_fifo_pkg::eth_keep_t     rx_axis_tkeep,
    output logic                        rx_axis_tvalid,
    input  wire                         rx_axis_tready,
    output logic                        rx_axis_tlast,

    output logic                        tx_fifo_overflow,
    output logic                        tx_fifo_bad_frame,
    output logic                        tx_fifo_good_frame,
    output logic                        rx_fifo_overflow,
    output logic                        rx_fifo_bad_frame,
    output logic                        rx_fifo_good_frame
);
    import eth_fifo_pkg::*;

    // Transmit path applies back-pressure to the user stream
    frame_fifo #(
        .drop_when_full (1'b0)
    ) tx_fifo (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .s_tdata    (tx_axis_tdata),
        .s_tkeep    (tx_axis_tkeep),
        .s_tvalid   (tx_axis_tvalid),
        .s_tlast    (tx_axis_tlast),
        .s_tuser    (tx_axis_tuser),
        .s_tready   (tx_axis_tready),
        .m_tdata    (tx_fifo_axis_tdata),
        .m_tkeep    (tx_fifo_axis_tkeep),
        .m_tvalid   (tx_fifo_axis_tvalid),
        .m_tlast    (tx_fifo_axis_tlast),
        .m_tready   (tx_fifo_axis_tready),
        .good_frame (tx_fifo_good_frame),
        .bad_frame  (tx_fifo_bad_frame),
        .overflow   (tx_fifo_overflow)
    );

    // MAC side cannot stall, so frames are dropped when full
    frame_fifo #(
        .drop_when_full (1'b1)
    ) rx_fifo (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .s_tdata    (rx_fifo_axis_tdata),
        .s_tkeep    (rx_fifo_axis_tkeep),
        .s_tvalid   (rx_fifo_axis_tvalid),
        .s_tlast    (rx_fifo_axis_tlast),
        .s_tuser    (rx_fifo_axis_tuser),
        .s_tready   (),
        .m_tdata    (rx_axis_tdata),
        .m_tkeep    (rx_axis_tkeep),
        .m_tvalid   (rx_axis_tvalid),
        .m_tlast    (rx_axis_tlast),
        .m_tready   (rx_axis_tready),
        .good_frame (rx_fifo_good_frame),
        .bad_frame  (rx_fifo_bad_frame),
        .overflow   (rx_fifo_overflow)
    );

endmodule

`default_nettype wire

// File: eth_frame_fifo_chk.sv
`timescale 1ns/1ps
`default_nettype none

module eth_frame_fifo_chk (
    input wire                          logic_clk,
    input wire                          logic_rst,
    input wire eth_fifo_pkg::eth_data_t tx_fifo_axis_tdata,
    input wire                          tx_fifo_axis_tvalid,
    input wire                          tx_fifo_axis_tready,
    input wire                          tx_fifo_axis_tlast,
    input wire eth_fifo_pkg::eth_data_t rx_axis_tdata,
    input wire                          rx_axis_tvalid,
    input wire                          rx_axis_tready,
    input wire                          rx_axis_tlast,
    input wire                          tx_fifo_overflow, tx_fifo_bad_frame, tx_fifo_good_frame,
    input wire                          rx_fifo_overflow, rx_fifo_bad_frame, rx_fifo_good_frame
);
    logic [5:0] status;

    assign status = {tx_fifo_overflow, tx_fifo_bad_frame, tx_fifo_good_frame,
                     rx_fifo_overflow, rx_fifo_bad_frame, rx_fifo_good_frame};

    // A stalled beat holds
    tx_hold: assert property (@(posedge logic_clk) disable iff (logic_rst)
        tx_fifo_axis_tvalid && !tx_fifo_axis_tready |=>
        $stable({tx_fifo_axis_tvalid, tx_fifo_axis_tdata, tx_fifo_axis_tlast}))
        else $error("tx_fifo_axis beat changed while stalled");

    rx_hold: assert property (@(posedge logic_clk) disable iff (logic_rst)
        rx_axis_tvalid && !rx_axis_tready |=>
        $stable({rx_axis_tvalid, rx_axis_tdata, rx_axis_tlast}))
        else $error("rx_axis beat changed while stalled");

    // At most one outcome per path
    status_onehot: assert property (@(posedge logic_clk) disable iff (logic_rst)
        $onehot0(status[5:3]) && $onehot0(status[2:0]))
        else $error("two status pulses of one path at once");

    status_single: assert property (@(posedge logic_clk) disable iff (logic_rst)
        (status & $past(status)) == 6'b0)
        else $error("status pulse longer than one cycle");

endmodule

`default_nettype wire

// File: tb_eth_frame_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_fifo_defines.svh"

module tb_eth_frame_fifo;
    import eth_fifo_pkg::*;

    typedef enum logic [1:0] {out_deliver, out_bad, out_overflow} outcome_t;

    // Keep and tuser apply to the last beat only
    typedef struct packed {
        logic      rx;
        int        len;
        logic      tuser;
        eth_keep_t keep;
        outcome_t  result;
    } row_t;

    localparam int row_count = 12;
    localparam row_t rows [row_count] = '{
        '{1'b0,  1, 1'b0, 8'h01, out_deliver},
        '{1'b0,  7, 1'b0, 8'h0f, out_deliver},
        '{1'b0, 20, 1'b0, 8'hff, out_deliver},
        '{1'b0,  5, 1'b1, 8'hff, out_bad},
        '{1'b0,  3, 1'b0, 8'h3f, out_deliver},
        '{1'b0, 70, 1'b0, 8'hff, out_overflow},
        '{1'b0, 12, 1'b0, 8'h07, out_deliver},
        // Receive sink stalled, the fourth frame finds no room
        '{1'b1, 20, 1'b0, 8'hff, out_deliver},
        '{1'b1, 20, 1'b0, 8'h03, out_deliver},
        '{1'b1, 20, 1'b0, 8'hff, out_deliver},
        '{1'b1, 20, 1'b0, 8'h1f, out_overflow},
        '{1'b1,  3, 1'b1, 8'hff, out_bad}
    };

    logic        logic_clk;
    logic        logic_rst;
    eth_data_t   beat_data;
    eth_keep_t   beat_keep;
    logic        beat_valid, beat_rx, beat_last, beat_user;
    logic        tx_axis_tready, tx_fifo_axis_tvalid, tx_fifo_axis_tready, tx_fifo_axis_tlast;
    logic        rx_axis_tvalid, rx_axis_tready, rx_axis_tlast;
    eth_data_t   tx_fifo_axis_tdata, rx_axis_tdata;
    eth_keep_t   tx_fifo_axis_tkeep, rx_axis_tkeep;
    logic        tx_fifo_overflow, tx_fifo_bad_frame, tx_fifo_good_frame;
    logic        rx_fifo_overflow, rx_fifo_bad_frame, rx_fifo_good_frame;
    // {tx overflow, tx bad, tx good, rx overflow, rx bad, rx good}
    logic [5:0]  exp_status;
    logic [15:0] data_lfsr;
    logic [15:0] ready_lfsr;
    fifo_word_t  exp_tx[$];
    fifo_word_t  exp_rx[$];
    int          mismatches;
    int          other_errors;
    logic        timed_out;

    eth_frame_fifo i_dut (
        .tx_axis_tdata       (beat_data),
        .tx_axis_tkeep       (beat_keep),
        .tx_axis_tvalid      (beat_valid && !beat_rx),
        .tx_axis_tlast       (beat_last),
        .tx_axis_tuser       (beat_user),
        .rx_fifo_axis_tdata  (beat_data),
        .rx_fifo_axis_tkeep  (beat_keep),
        .rx_fifo_axis_tvalid (beat_valid && beat_rx),
        .rx_fifo_axis_tlast  (beat_last),
        .rx_fifo_axis_tuser  (beat_user),
        .*
    );

    bind eth_frame_fifo eth_frame_fifo_chk i_chk (.*);

    always #20 logic_clk = ~logic_clk;

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
    endfunction

    task automatic take_bits(input int n, output eth_data_t value);
        value = '0;
        for (int b = 0; b < n; b++) begin
            value     = {value[`ETH_DATA_W-2:0], data_lfsr[0]};
            data_lfsr = lfsr_next(data_lfsr);
        end
    endtask

    task automatic check_data(input string name, input eth_data_t got, input eth_data_t want);
        if (got !== want) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, want);
            mismatches++;
        end
    endtask

    task automatic check_keep(input string name, input eth_keep_t got, input eth_keep_t want);
        if (got !== want) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, want);
            mismatches++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("mismatch at %0t: %s is %b, expected %b", $time, name, got, want);
            mismatches++;
        end
    endtask

    task automatic finish_run();
        $display("mismatches: %0d, other failures: %0d", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        other_errors++;
        timed_out = 1'b1;
    endtask

    task automatic pop_and_compare(input logic rx, input eth_data_t data, input eth_keep_t keep,
                                   input logic last);
        fifo_word_t want;
        string      path;
        path = rx ? "rx_axis" : "tx_fifo_axis";
        if ((rx && exp_rx.size() == 0) || (!rx && exp_tx.size() == 0)) begin
            $display("unexpected beat at %0t on %s, no frame was due there", $time, path);
            other_errors++;
        end else begin
            if (rx) begin
                want = exp_rx.pop_front();
            end else begin
                want = exp_tx.pop_front();
            end
            check_data({path, "_tdata"}, data, want[`ETH_DATA_W-1:0]);
            check_keep({path, "_tkeep"}, keep, want[`ETH_DATA_W +: `ETH_KEEP_W]);
            check_bit({path, "_tlast"}, last, want[`ETH_DATA_W+`ETH_KEEP_W]);
        end
    endtask

    task automatic send_frame(input row_t r);
        eth_data_t data;
        int        waited;
        for (int i = 0; i < r.len; i++) begin
            take_bits(`ETH_DATA_W, data);
            @(negedge logic_clk);
            beat_valid = 1'b1;
            beat_rx    = r.rx;
            beat_data  = data;
            beat_last  = (i == r.len - 1);
            beat_keep  = beat_last ? r.keep : '1;
            beat_user  = beat_last && r.tuser;
            if (r.result == out_deliver && r.rx) begin
                exp_rx.push_back({beat_last, beat_keep, beat_data});
            end else if (r.result == out_deliver) begin
                exp_tx.push_back({beat_last, beat_keep, beat_data});
            end
            // Receive input has no ready
            for (waited = 0; waited < 1000; waited++) begin
                @(posedge logic_clk);
                if (r.rx || tx_axis_tready) begin
                    break;
                end
            end
            if (waited == 1000) begin
                report_timeout("tx_axis_tready");
                return;
            end
        end
        // Status pulse is due in the cycle after the last beat
        @(negedge logic_clk);
        beat_valid = 1'b0;
        exp_status = 6'b1 << (int'(r.result) + (r.rx ? 0 : 3));
        @(negedge logic_clk);
        exp_status = '0;
    endtask

    // Transmit sink stalls at random
    always @(negedge logic_clk) begin
        tx_fifo_axis_tready <= ready_lfsr[0];
        ready_lfsr          <= lfsr_next(ready_lfsr);
    end

    always @(posedge logic_clk) begin
        if (!logic_rst) begin
            if (tx_fifo_axis_tvalid && tx_fifo_axis_tready) begin
                pop_and_compare(1'b0, tx_fifo_axis_tdata, tx_fifo_axis_tkeep, tx_fifo_axis_tlast);
            end
            if (rx_axis_tvalid && rx_axis_tready) begin
                pop_and_compare(1'b1, rx_axis_tdata, rx_axis_tkeep, rx_axis_tlast);
            end
            check_bit("tx_fifo_overflow", tx_fifo_overflow, exp_status[5]);
            check_bit("tx_fifo_bad_frame", tx_fifo_bad_frame, exp_status[4]);
            check_bit("tx_fifo_good_frame", tx_fifo_good_frame, exp_status[3]);
            check_bit("rx_fifo_overflow", rx_fifo_overflow, exp_status[2]);
            check_bit("rx_fifo_bad_frame", rx_fifo_bad_frame, exp_status[1]);
            check_bit("rx_fifo_good_frame", rx_fifo_good_frame, exp_status[0]);
        end
    end

    initial begin
        int waited;
        logic_clk           = 1'b0;
        logic_rst           = 1'b1;
        beat_valid          = 1'b0;
        beat_rx             = 1'b0;
        beat_data           = '0;
        beat_keep           = '0;
        beat_last           = 1'b0;
        beat_user           = 1'b0;
        rx_axis_tready      = 1'b0;
        tx_fifo_axis_tready = 1'b0;
        exp_status          = '0;
        data_lfsr           = 16'd84;
        ready_lfsr          = 16'd84;
        mismatches          = 0;
        other_errors        = 0;
        timed_out           = 1'b0;
        repeat (2) @(posedge logic_clk);
        @(negedge logic_clk);
        logic_rst = 1'b0;
        check_bit("tx_fifo_axis_tvalid", tx_fifo_axis_tvalid, 1'b0);
        check_bit("rx_axis_tvalid", rx_axis_tvalid, 1'b0);
        check_bit("tx_axis_tready", tx_axis_tready, 1'b1);
        for (int i = 0; i < row_count && !timed_out; i++) begin
            send_frame(rows[i]);
        end
        if (!timed_out) begin
            // Release the stored receive frames
            rx_axis_tready = 1'b1;
            for (waited = 0; waited < 2000; waited++) begin
                @(negedge logic_clk);
                if (exp_tx.size() == 0 && exp_rx.size() == 0) begin
                    break;
                end
            end
            if (waited == 2000) begin
                report_timeout("the expected beats to leave the outputs");
            end else begin
                // Time for a stray beat of a dropped frame to show up
                repeat (20) @(negedge logic_clk);
            end
        end
        finish_run();
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
eth_fifo_pkg.sv
frame_fifo_ram.sv
frame_fifo_write.sv
frame_fifo_read.sv
frame_fifo.sv
eth_frame_fifo.sv
eth_frame_fifo_chk.sv
tb_eth_frame_fifo.sv

// File: Bender.yml
package:
  name: eth_frame_fifo

sources:
  - include_dirs:
      - .
    files:
      - eth_fifo_pkg.sv
      - frame_fifo_ram.sv
      - frame_fifo_write.sv
      - frame_fifo_read.sv
      - frame_fifo.sv
      - eth_frame_fifo.sv
  - target: test
    include_dirs:
      - .
    files:
      - eth_frame_fifo_chk.sv
      - tb_eth_frame_fifo.sv
